// ==== include/alu_cfg.svh ====
/*
 * Word width, bus addresses and action codes of the ALU board.
 * Spare action codes are left undecoded.
 */
`ifndef ALU_CFG_SVH
`define ALU_CFG_SVH

`define ALU_WIDTH     16   // Fixed by the instruction set

`define ALU_RADDR_B   7    // Read port B
`define ALU_WADDR_B   7    // Write port B
`define ALU_RADDR_OP  8    // 8..15 read an op result, low 3 bits pick the op

`define ALU_ACT_CPL   1    // Complement L
`define ALU_ACT_CLL   2    // Clear L
`define ALU_ACT_SRU   3    // Start the shifter

`endif

// ==== source/alu_pkg.sv ====
/*
 * Shared types of the ALU board.
 * Widths come from alu_cfg.svh, the word is always 16 bits.
 */
`include "alu_cfg.svh"

package alu_pkg;

   typedef logic [`ALU_WIDTH-1:0] word_t;      // One data word
   typedef logic [4:0]            bus_addr_t;  // Microcode read/write address
   typedef logic [3:0]            action_t;    // Microcode action code

   // Shift field from IR[6:0]
   // [3:0] distance, [4] right, [5] arithmetic, [6] rotate
   typedef logic [6:0]            sru_field_t;

   // Operation select, taken from raddr[2:0]
   typedef enum logic [2:0] {
      op_add = 3'd0,   // A + B
      op_adc = 3'd1,   // A + B + L
      op_and = 3'd2,
      op_or  = 3'd3,
      op_xor = 3'd4,
      op_not = 3'd5,   // ~A
      op_sub = 3'd6,   // A + ~B + 1
      op_inc = 3'd7    // B + 1
   } alu_op_e;

   // Shifter FSM
   typedef enum logic {
      sru_idle,
      sru_shift
   } sru_state_e;

endpackage

// ==== source/alu_bus_if.sv ====
/*
 * Internal buses of the ALU board.
 * All strobes are single-cycle and decoded combinationally.
 */
`timescale 1ns/1ps

// Decoded microcode strobes
interface alu_ctrl_if;
   logic op_read;     // raddr 8..15
   logic b_read;      // raddr 7
   logic b_write;     // waddr 7
   logic cpl;         // Action CPL
   logic cll;         // Action CLL
   logic sru_start;   // Action SRU

   modport decoder  (output op_read, b_read, b_write, cpl, cll, sru_start);
   modport operands (input b_read, b_write);
   modport unit     (input op_read, cpl, cll, sru_start);
endinterface

// Flag update sources feeding the L and V registers
interface alu_flag_if;
   logic arith_carry;   // Carry out of the adder
   logic arith_ovf;     // Signed overflow of the adder
   logic arith_set;     // Arithmetic op read this cycle
   logic sru_link;      // L after the current shift step
   logic sru_link_we;   // Shifter owns L this cycle

   modport arith (output arith_carry, arith_ovf, arith_set);
   modport sru   (output sru_link, sru_link_we);
   modport flag  (input arith_carry, arith_ovf, arith_set, sru_link, sru_link_we);
endinterface

// ==== source/alu_decoder.sv ====
/*
 * Microcode field decoder.
 * Pure combinational, strobes follow raddr/waddr/action in the same cycle.
 * Action codes other than CPL, CLL and SRU produce no strobe.
 */
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_decoder (
   input  alu_pkg::bus_addr_t raddr,
   input  alu_pkg::bus_addr_t waddr,
   input  alu_pkg::action_t   action,
   alu_ctrl_if.decoder        ctrl
);
   import alu_pkg::*;

   // Op results live at 8..15, so only the top two address bits matter
   localparam bus_addr_t op_mask = 5'b11000;

   ////////////////////
   // Read address
   ////////////////////

   assign ctrl.op_read = (raddr & op_mask) == bus_addr_t'(`ALU_RADDR_OP);
   assign ctrl.b_read  = (raddr == bus_addr_t'(`ALU_RADDR_B));   // Port B onto bus

   ////////////////////
   // Write address
   ////////////////////

   // Port B loads from the bus on the next clk4 edge
   assign ctrl.b_write = (waddr == bus_addr_t'(`ALU_WADDR_B));

   ////////////////////
   // Action code
   ////////////////////

   assign ctrl.cpl       = (action == action_t'(`ALU_ACT_CPL));  // Flip L
   assign ctrl.cll       = (action == action_t'(`ALU_ACT_CLL));  // Clear L
   assign ctrl.sru_start = (action == action_t'(`ALU_ACT_SRU));  // Kick the shifter

endmodule

// ==== source/alu_operand_regs.sv ====
/*
 * ALU operand ports A and B.
 * A samples ac on every edge, so op reads see ac from the cycle before.
 * While the shifter is busy B follows the shifter and ignores bus writes.
 */
`timescale 1ns/1ps

module alu_operand_regs (
   input  logic           clk4,
   input  logic           reset,
   input  alu_pkg::word_t ac,        // Accumulator from the register board
   input  alu_pkg::word_t ibus_in,
   input  alu_pkg::word_t sru_b,     // Next B from the shifter
   input  logic           sru_busy,
   alu_ctrl_if.operands   ctrl,
   output alu_pkg::word_t a,
   output alu_pkg::word_t b,
   output alu_pkg::word_t b_bus      // B gated for the bus merge
);

   ////////////////////
   // Port A and B
   ////////////////////

   always_ff @(posedge clk4) begin
      if (reset) begin
         a <= '0;
         b <= '0;
      end else begin
         a <= ac;                   // Latched every cycle
         if (sru_busy) begin
            b <= sru_b;             // One shift step per edge
         end else if (ctrl.b_write) begin
            b <= ibus_in;
         end
      end
   end

   // Zero when not addressed, the top level ORs all drivers
   assign b_bus = ctrl.b_read ? b : '0;

endmodule

// ==== source/alu_op_unit.sv ====
/*
 * Eight-operation ALU function block, combinational.
 * The op is raddr[2:0], result goes on the bus only during an op read.
 * Carry and overflow are offered every cycle, arith_set marks when to take them.
 */
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_op_unit (
   input  alu_pkg::word_t   a,
   input  alu_pkg::word_t   b,
   input  logic             link,    // Current L, carry in for adc
   input  alu_pkg::alu_op_e op,
   alu_ctrl_if.unit         ctrl,
   alu_flag_if.arith        flags,
   output alu_pkg::word_t   result_bus
);
   import alu_pkg::*;

   localparam int msb = `ALU_WIDTH - 1;

   word_t                 add_x;      // Adder operands
   word_t                 add_y;
   logic                  add_cin;
   logic [`ALU_WIDTH:0]   sum;        // Top bit is the carry
   word_t                 result;
   logic                  is_arith;

   ////////////////////
   // Adder operand mux
   ////////////////////

   always_comb begin
      add_x   = a;
      add_y   = b;
      add_cin = 1'b0;
      case (op)
         op_adc:  add_cin = link;
         op_sub: begin
            add_y   = ~b;             // Two's complement subtract
            add_cin = 1'b1;
         end
         op_inc: begin
            add_x   = b;              // Increment works on B
            add_y   = '0;
            add_cin = 1'b1;
         end
         default: ;
      endcase
   end

   assign sum = {1'b0, add_x} + {1'b0, add_y} + (`ALU_WIDTH+1)'(add_cin);

   ////////////////////
   // Result select
   ////////////////////

   always_comb begin
      case (op)
         op_and:  result = a & b;
         op_or:   result = a | b;
         op_xor:  result = a ^ b;
         op_not:  result = ~a;
         default: result = sum[msb:0];   // add, adc, sub, inc
      endcase
   end

   assign is_arith = (op == op_add) || (op == op_adc) || (op == op_sub) || (op == op_inc);

   // Flag sources, taken by alu_flags on the edge ending the read
   assign flags.arith_carry = sum[`ALU_WIDTH];
   assign flags.arith_ovf   = (add_x[msb] == add_y[msb]) && (sum[msb] != add_x[msb]);
   assign flags.arith_set   = ctrl.op_read & is_arith;

   assign result_bus = ctrl.op_read ? result : '0;

endmodule

// ==== source/alu_sru.sv ====
/*
 * Serial shift/rotate unit, one bit per clk4 edge.
 * A start with distance 0, or a start while busy, is dropped.
 * Rotates go through L, making a 17-bit ring. Arithmetic only affects right shifts.
 */
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_sru (
   input  logic               clk4,
   input  logic               reset,
   alu_ctrl_if.unit           ctrl,
   input  alu_pkg::sru_field_t field,   // IR[6:0]
   input  alu_pkg::word_t     b,        // Current port B
   input  logic               link,     // Current L
   alu_flag_if.sru            flags,
   output alu_pkg::word_t     sru_b,    // B after this step
   output logic               sru_busy
);
   import alu_pkg::*;

   localparam int msb       = `ALU_WIDTH - 1;
   localparam int right_bit = 4;   // Field bit positions
   localparam int arith_bit = 5;
   localparam int rot_bit   = 6;

   sru_state_e state;
   sru_field_t mode;          // Field captured at start
   logic [3:0] count;         // Steps left, including this one
   logic       step_l;        // L after this step

   ////////////////////
   // Control FSM
   ////////////////////

   always_ff @(posedge clk4) begin
      if (reset) begin
         state <= sru_idle;
         mode  <= '0;
         count <= '0;
      end else begin
         case (state)
            sru_idle: begin
               if (ctrl.sru_start && (field[3:0] != 4'd0)) begin
                  mode  <= field;
                  count <= field[3:0];
                  state <= sru_shift;
               end
            end
            sru_shift: begin
               count <= count - 4'd1;
               if (count == 4'd1) begin
                  state <= sru_idle;      // Last step lands on this edge
               end
            end
            default: state <= sru_idle;
         endcase
      end
   end

   assign sru_busy = (state == sru_shift);   // High for exactly d cycles

   ////////////////////
   // Single step
   ////////////////////

   always_comb begin
      if (mode[rot_bit]) begin
         if (mode[right_bit]) begin
            sru_b  = {link, b[msb:1]};    // L enters at the top
            step_l = b[0];
         end else begin
            sru_b  = {b[msb-1:0], link};  // L enters at the bottom
            step_l = b[msb];
         end
      end else if (mode[right_bit]) begin
         sru_b  = {mode[arith_bit] & b[msb], b[msb:1]};   // Keep sign if arithmetic
         step_l = b[0];
      end else begin
         sru_b  = {b[msb-1:0], 1'b0};
         step_l = b[msb];
      end
   end

   // Shifter owns L for every busy cycle
   assign flags.sru_link    = step_l;
   assign flags.sru_link_we = sru_busy;

endmodule

// ==== source/alu_flags.sv ====
/*
 * Link (L) and overflow (V) flag registers.
 * Priority: reset, flag_we, cll, cpl, shifter, arithmetic.
 * Only flag_we and arithmetic reads touch V. Arithmetic is dropped while busy.
 */
`timescale 1ns/1ps

module alu_flags (
   input  logic           clk4,
   input  logic           reset,
   alu_ctrl_if.unit       ctrl,
   alu_flag_if.flag       flags,
   input  logic           flag_we,    // Bus write of the flag word
   input  alu_pkg::word_t ibus_in,
   input  logic           sru_busy,
   output logic           fl,
   output logic           fv
);

   localparam int l_bit = 12;   // Flag positions in the bus word
   localparam int v_bit = 13;

   logic arith_we;

   assign arith_we = flags.arith_set & ~sru_busy;

   ////////////////////
   // L and V
   ////////////////////

   always_ff @(posedge clk4) begin
      if (reset) begin
         fl <= 1'b0;
         fv <= 1'b0;
      end else if (flag_we) begin
         fl <= ibus_in[l_bit];
         fv <= ibus_in[v_bit];
      end else begin
         if (ctrl.cll) begin
            fl <= 1'b0;
         end else if (ctrl.cpl) begin
            fl <= ~fl;
         end else if (flags.sru_link_we) begin
            fl <= flags.sru_link;       // Shift step output
         end else if (arith_we) begin
            fl <= flags.arith_carry;
         end
         if (arith_we) begin
            fv <= flags.arith_ovf;      // V has no other source
         end
      end
   end

endmodule

// ==== source/alu_board.sv ====
/*
 * ALU board top level, single clk4 edge.
 * The processor bus is split into ibus_in, ibus_out and ibus_oe.
 * ibus_out is zero whenever ibus_oe is low.
 */
`timescale 1ns/1ps

module alu_board (
   input  logic                clk4,
   input  logic                reset,
   input  alu_pkg::bus_addr_t  raddr,
   input  alu_pkg::bus_addr_t  waddr,
   input  alu_pkg::action_t    action,
   input  alu_pkg::word_t      ac,
   input  alu_pkg::sru_field_t ir,
   input  logic                flag_we,
   input  alu_pkg::word_t      ibus_in,
   output alu_pkg::word_t      ibus_out,
   output logic                ibus_oe,
   output logic                fl,
   output logic                fv,
   output logic                sru_busy
);
   import alu_pkg::*;

   alu_ctrl_if ctrl_if ();
   alu_flag_if flag_if ();

   word_t   a;
   word_t   b;
   word_t   sru_b;
   word_t   b_bus;        // Gated drivers
   word_t   result_bus;
   alu_op_e op_sel;

   assign op_sel = alu_op_e'(raddr[2:0]);

   alu_decoder u_decoder (.raddr(raddr), .waddr(waddr), .action(action), .ctrl(ctrl_if));

   alu_operand_regs u_operands (.clk4(clk4), .reset(reset), .ac(ac), .ibus_in(ibus_in),
      .sru_b(sru_b), .sru_busy(sru_busy), .ctrl(ctrl_if), .a(a), .b(b), .b_bus(b_bus));

   alu_op_unit u_op (.a(a), .b(b), .link(fl), .op(op_sel), .ctrl(ctrl_if),
      .flags(flag_if), .result_bus(result_bus));

   alu_sru u_sru (.clk4(clk4), .reset(reset), .ctrl(ctrl_if), .field(ir), .b(b),
      .link(fl), .flags(flag_if), .sru_b(sru_b), .sru_busy(sru_busy));

   alu_flags u_flags (.clk4(clk4), .reset(reset), .ctrl(ctrl_if), .flags(flag_if),
      .flag_we(flag_we), .ibus_in(ibus_in), .sru_busy(sru_busy), .fl(fl), .fv(fv));

   ////////////////////
   // Bus merge
   ////////////////////

   // At most one driver is non-zero in a cycle
   assign ibus_out = result_bus | b_bus;
   assign ibus_oe  = ctrl_if.op_read | ctrl_if.b_read;

endmodule

// ==== sim/alu_board_sva.sv ====
/*
 * Assertions bound into alu_board.
 * The busy model assumes a start is taken only when idle and the distance is non-zero.
 */
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_board_sva (
   input logic                clk4,
   input logic                reset,
   input alu_pkg::bus_addr_t  raddr,
   input alu_pkg::action_t    action,
   input alu_pkg::sru_field_t ir,
   input logic                flag_we,
   input logic                ibus_oe,
   input logic                sru_busy,
   input logic                fl,
   input logic                fv
);
   import alu_pkg::*;

   logic [3:0] left;       // Busy cycles still expected
   logic       rd_addr;    // B or an op result addressed
   logic       arith_rd;   // add, adc, sub, inc read
   logic       flag_src;   // Anything allowed to touch L or V

   assign rd_addr  = (raddr == bus_addr_t'(`ALU_RADDR_B)) || (raddr[4:3] == 2'b01);
   assign arith_rd = (raddr[4:3] == 2'b01) && ((raddr[2:1] == 2'b00) || (raddr[2:1] == 2'b11));
   assign flag_src = flag_we || sru_busy || arith_rd || (action == action_t'(`ALU_ACT_CPL))
                     || (action == action_t'(`ALU_ACT_CLL));

   always_ff @(posedge clk4) begin
      if (reset) begin
         left <= '0;
      end else if (left != 4'd0) begin
         left <= left - 4'd1;                 // One step per edge
      end else if ((action == action_t'(`ALU_ACT_SRU)) && (ir[3:0] != 4'd0)) begin
         left <= ir[3:0];
      end
   end

   ////////////////////
   // Checks
   ////////////////////

   a_oe_addr: assert property (@(posedge clk4) ibus_oe |-> rd_addr)
      else $error("ibus_oe high without a read address");
   a_busy_reset: assert property (@(posedge clk4) reset |=> !sru_busy)
      else $error("sru_busy high right after reset");
   a_busy_len: assert property (@(posedge clk4) disable iff (reset) sru_busy == (left != 4'd0))
      else $error("sru_busy length differs from the shift distance");
   a_flags_hold: assert property (@(posedge clk4) disable iff (reset)
      !flag_src |=> ($stable(fl) && $stable(fv)))
      else $error("fl or fv changed with no update source");

endmodule

bind alu_board alu_board_sva u_sva (.*);

// ==== sim/alu_board_tb.sv ====
/*
 * Testbench for the ALU board, tests and expected values come from sim/alu_golden.txt.
 * Run from the project root so the golden file path resolves.
 * Inputs change on the rising clk4 edge, outputs are sampled on the falling edge.
 */
`timescale 1ns/1ps
`include "alu_cfg.svh"

module alu_board_tb;
   import alu_pkg::*;

   localparam int clk_period      = 8;
   localparam int cycles_per_test = 40;   // Watchdog budget per golden line
   localparam int busy_limit      = 20;   // Longest shift is 15 steps

   logic       clk4;
   logic       reset;
   bus_addr_t  raddr;
   bus_addr_t  waddr;
   action_t    action;
   word_t      ac;
   sru_field_t ir;
   logic       flag_we;
   word_t      ibus_in;
   word_t      ibus_out;
   logic       ibus_oe;
   logic       fl;
   logic       fv;
   logic       sru_busy;

   // Golden table, one entry per test line
   logic [15:0] t_kind[$];
   logic [15:0] t_opf[$];
   logic [15:0] t_ac[$];
   logic [15:0] t_b[$];
   logic [15:0] t_flags[$];
   logic [15:0] t_word[$];
   logic [15:0] t_l[$];
   logic [15:0] t_v[$];

   int   checks;
   int   mismatches;
   int   other_errors;
   int   rnd_init;
   int   gap;
   logic loaded;

   alu_board uut (.*);

   initial begin
      clk4 = 1'b0;
      forever #(clk_period / 2) clk4 = ~clk4;
   end

   // Watchdog, armed once the table size is known
   initial begin
      wait (loaded);
      repeat (8 + 16 + cycles_per_test * t_kind.size()) @(posedge clk4);
      $display("Watchdog expired, the tests did not complete in time");
      $display("Simulation finished: FAIL");
      $finish;
   end

   ////////////////////
   // Helpers
   ////////////////////

   task automatic check_value(input string name, input logic [15:0] actual,
                              input logic [15:0] expected);
      checks++;
      if (actual !== expected) begin
         mismatches++;
         $display("mismatch at %0t ns: %s = %h, expected %h", $time, name, actual, expected);
      end
   endtask

   task automatic load_golden();
      int          fd;
      int          ch;
      int          n;
      string       tok;
      logic [15:0] f[8];
      fd = $fopen("sim/alu_golden.txt", "r");
      if (fd == 0) begin
         other_errors++;
         $display("Cannot open the golden file sim/alu_golden.txt");
         return;
      end
      while ($fscanf(fd, "%s", tok) == 1) begin
         if (tok[0] == "#") begin
            ch = $fgetc(fd);                  // Skip the rest of a comment line
            while ((ch != 10) && (ch != -1)) begin
               ch = $fgetc(fd);
            end
         end else begin
            n = $sscanf(tok, "%h", f[0]);
            n += $fscanf(fd, "%h %h %h %h %h %h %h", f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
            if (n != 8) begin
               other_errors++;
               $display("Golden line %0d is incomplete", t_kind.size() + 1);
            end else begin
               t_kind.push_back(f[0]);
               t_opf.push_back(f[1]);
               t_ac.push_back(f[2]);
               t_b.push_back(f[3]);
               t_flags.push_back(f[4]);
               t_word.push_back(f[5]);
               t_l.push_back(f[6]);
               t_v.push_back(f[7]);
            end
         end
      end
      $fclose(fd);
   endtask

   task automatic drive_idle();
      raddr   <= '0;   // 0 reads nothing
      waddr   <= '0;
      action  <= '0;
      flag_we <= 1'b0;
      ibus_in <= '0;
   endtask

   // L on bus bit 12, V on bit 13
   task automatic set_flags(input logic [1:0] lv);
      @(posedge clk4);
      drive_idle();
      flag_we <= 1'b1;
      ibus_in <= word_t'({lv[1], lv[0]}) << 12;
   endtask

   task automatic write_b(input word_t value, input word_t ac_value);
      @(posedge clk4);
      drive_idle();
      waddr   <= bus_addr_t'(`ALU_WADDR_B);
      ibus_in <= value;
      ac      <= ac_value;    // A takes it on the next edge
   endtask

   task automatic check_flags(input int i);
      check_value("fl", 16'(fl), t_l[i]);
      check_value("fv", 16'(fv), t_v[i]);
   endtask

   ////////////////////
   // Test kinds
   ////////////////////

   task automatic check_b_readback(input int i);
      write_b(t_b[i], t_ac[i]);
      @(posedge clk4);
      drive_idle();
      raddr <= bus_addr_t'(`ALU_RADDR_B);
      @(negedge clk4);
      check_value("ibus_out", ibus_out, t_word[i]);
      check_value("ibus_oe", 16'(ibus_oe), 16'd1);
      @(posedge clk4);
      drive_idle();
      @(negedge clk4);
      check_value("ibus_oe", 16'(ibus_oe), 16'd0);   // Nothing addressed
      check_value("ibus_out", ibus_out, 16'h0000);
      check_flags(i);
   endtask

   task automatic exercise_op(input int i);
      write_b(t_b[i], t_ac[i]);
      @(posedge clk4);
      drive_idle();
      raddr <= bus_addr_t'(`ALU_RADDR_OP + int'(t_opf[i][2:0]));
      ac    <= ~t_ac[i];                     // Port A still holds last cycle's ac
      @(negedge clk4);
      check_value("ibus_out", ibus_out, t_word[i]);
      check_value("ibus_oe", 16'(ibus_oe), 16'd1);
      @(posedge clk4);                       // Flags land on this edge
      drive_idle();
      @(negedge clk4);
      check_flags(i);
   endtask

   task automatic apply_flag_action(input int i);
      @(posedge clk4);
      drive_idle();
      action  <= action_t'(t_opf[i][3:0]);
      flag_we <= t_opf[i][4];
      ibus_in <= t_b[i];
      @(negedge clk4);
      check_value("ibus_out", ibus_out, t_word[i]);
      check_value("ibus_oe", 16'(ibus_oe), 16'd0);
      @(posedge clk4);
      drive_idle();
      @(negedge clk4);
      check_flags(i);
   endtask

   task automatic run_shift(input int i);
      int busy_cycles;
      write_b(t_b[i], t_ac[i]);
      @(posedge clk4);
      drive_idle();
      action <= action_t'(`ALU_ACT_SRU);
      ir     <= sru_field_t'(t_opf[i][6:0]);
      @(posedge clk4);                       // Busy rises here when d > 0
      drive_idle();
      if (t_kind[i] == 16'd4) begin
         waddr   <= bus_addr_t'(`ALU_WADDR_B);   // Must be ignored
         ibus_in <= t_ac[i];
      end
      busy_cycles = 0;
      @(negedge clk4);
      while (sru_busy && (busy_cycles <= busy_limit)) begin
         busy_cycles++;
         @(posedge clk4);
         drive_idle();
         @(negedge clk4);
      end
      if (busy_cycles > busy_limit) begin
         other_errors++;
         $display("Shifter stayed busy for more than %0d cycles", busy_limit);
      end
      check_value("sru_busy cycles", 16'(busy_cycles), 16'(t_opf[i][3:0]));
      @(posedge clk4);
      drive_idle();
      raddr <= bus_addr_t'(`ALU_RADDR_B);
      @(negedge clk4);
      check_value("ibus_out", ibus_out, t_word[i]);
      check_flags(i);
      @(posedge clk4);
      drive_idle();
   endtask

   ////////////////////
   // Main sequence
   ////////////////////

   initial begin
      rnd_init     = $urandom(34);
      checks       = 0;
      mismatches   = 0;
      other_errors = 0;
      loaded       = 1'b0;
      reset        = 1'b1;
      raddr        = '0;
      waddr        = '0;
      action       = '0;
      ac           = '0;
      ir           = '0;
      flag_we      = 1'b0;
      ibus_in      = '0;
      load_golden();
      loaded = 1'b1;
      repeat (8) @(posedge clk4);
      reset <= 1'b0;
      @(negedge clk4);
      check_value("sru_busy", 16'(sru_busy), 16'd0);   // State after reset
      check_value("ibus_oe", 16'(ibus_oe), 16'd0);
      check_value("fl", 16'(fl), 16'd0);
      check_value("fv", 16'(fv), 16'd0);
      for (int i = 0; i < t_kind.size(); i++) begin
         set_flags(t_flags[i][1:0]);
         case (t_kind[i])
            16'd0:        check_b_readback(i);
            16'd1:        exercise_op(i);
            16'd2:        apply_flag_action(i);
            16'd3, 16'd4: run_shift(i);
            default: begin
               other_errors++;
               $display("Unknown test kind %0h on golden line %0d", t_kind[i], i + 1);
            end
         endcase
         gap = $urandom % 4;                 // Idle gap of 0 to 3 cycles
         repeat (gap) @(posedge clk4);
      end
      @(posedge clk4);
      $display("Checks: %0d, mismatches: %0d, other errors: %0d",
               checks, mismatches, other_errors);
      if ((mismatches == 0) && (other_errors == 0)) begin
         $display("Simulation finished: PASS");
      end else begin
         $display("Simulation finished: FAIL");
      end
      $finish;
   end

endmodule

// ==== list.f ====
+incdir+include
source/alu_pkg.sv
source/alu_bus_if.sv
source/alu_decoder.sv
source/alu_operand_regs.sv
source/alu_op_unit.sv
source/alu_sru.sv
source/alu_flags.sv
source/alu_board.sv
sim/alu_board_sva.sv
sim/alu_board_tb.sv

// ==== sim/alu_golden.txt ====
# kind opf ac b flags word l v, all hex, flags bit0 = L and bit1 = V before the test
# kind 0 B readback, 1 op read, 2 action (opf[4] = flag_we), 3 shift, 4 shift + B write
0 00 0000 a5c3 0 a5c3 0 0
0 00 0000 5a3c 3 5a3c 1 1
1 00 7fff 0001 0 8000 0 1
1 01 1234 0001 1 1236 0 0
1 01 8000 8000 1 0001 1 1
1 02 f0f0 ff00 3 f000 1 1
1 03 f0f0 0f0f 1 ffff 1 0
1 04 aaaa ffff 2 5555 0 1
1 05 1234 0000 0 edcb 0 0
1 06 0005 0003 0 0002 1 0
1 06 8000 0001 0 7fff 1 1
1 07 1111 ffff 2 0000 1 0
2 02 0000 0000 3 0000 0 1
2 01 0000 0000 0 0000 1 0
2 12 0000 3000 0 0000 1 1
2 11 0000 2000 0 0000 0 1
3 04 0000 f421 0 4210 1 0
3 13 0000 8005 2 1000 1 1
3 32 0000 8004 1 e001 0 0
3 45 0000 8001 1 0038 0 0
3 53 0000 0005 2 4000 1 1
3 10 0000 1234 1 1234 1 0
4 02 ffff 00ff 0 03fc 0 0
